// File: mem_pkg.sv
package mem_pkg;

   // Byte address and data word widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 16;

   // Cache geometry
   localparam int NUM_WAYS = 2;
   localparam int WAY_W = $clog2(NUM_WAYS);
   localparam int INDEX_W = 8;
   localparam int TAG_W = 5;
   localparam int WORD_W = 2;
   localparam int WORDS_PER_BLOCK = 4;
   localparam int NUM_SETS = 1 << INDEX_W;

   // Field positions in the byte address, bit 0 unused
   localparam int INDEX_LSB = 8;
   localparam int TAG_LSB = 3;
   localparam int WORD_LSB = 1;

   // Backing memory, word addressed
   localparam int MEM_WORDS = 32768;
   localparam int MEM_ADDR_W = 15;
   localparam int MEM_READ_LATENCY = 2;

   // Access controller states
   localparam int STATE_W = 2;
   localparam logic [STATE_W-1:0] S_IDLE = 2'd0;
   localparam logic [STATE_W-1:0] S_WRITEBACK = 2'd1;
   localparam logic [STATE_W-1:0] S_FILL = 2'd2;
   localparam logic [STATE_W-1:0] S_RETRY = 2'd3;

endpackage

// File: cache_way.sv
`timescale 1ns/1ns

module cache_way (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         en,
   input  logic [mem_pkg::INDEX_W-1:0]  index,
   input  logic [mem_pkg::WORD_W-1:0]   word,
   input  logic [mem_pkg::TAG_W-1:0]    tag_in,
   input  logic [mem_pkg::DATA_W-1:0]   data_in,
   input  logic                         wr,
   input  logic                         fill,
   input  logic                         mark_dirty,
   output logic                         hit,
   output logic                         valid,
   output logic                         dirty,
   output logic [mem_pkg::TAG_W-1:0]    tag_out,
   output logic [mem_pkg::DATA_W-1:0]   data_out
);
   import mem_pkg::*;

   // Per-set tag and status bits
   logic [TAG_W-1:0]          tag_mem [NUM_SETS];
   logic [NUM_SETS-1:0]       valid_bits;
   logic [NUM_SETS-1:0]       dirty_bits;
   // Block data, one row per {index, word}
   logic [DATA_W-1:0]         data_mem [NUM_SETS*WORDS_PER_BLOCK];
   logic [INDEX_W+WORD_W-1:0] data_addr;
   logic                      write_en;

   assign data_addr = {index, word};

   // Lookup is purely combinational
   assign tag_out = tag_mem[index];
   assign valid = valid_bits[index];
   assign dirty = dirty_bits[index];
   assign data_out = data_mem[data_addr];
   assign hit = valid && (tag_out == tag_in);

   // Fill writes always land; compare writes only on this way's hit
   assign write_en = en && wr && (fill || hit);

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else if (write_en) begin
         if (fill) begin
            // Fresh block from memory is clean
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;
         end else if (mark_dirty) begin
            dirty_bits[index] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (write_en) begin
         data_mem[data_addr] <= data_in;
         // New tag loaded with each fill word
         if (fill) begin
            tag_mem[index] <= tag_in;
         end
      end
   end

endmodule

// File: way_select.sv
`timescale 1ns/1ns

module way_select (
   input  logic                                      clk,
   input  logic                                      rst,
   input  logic                                      choose,
   input  logic [mem_pkg::NUM_WAYS-1:0]              hit,
   input  logic [mem_pkg::NUM_WAYS-1:0]              valid,
   input  logic [mem_pkg::NUM_WAYS-1:0]              dirty,
   input  logic [mem_pkg::NUM_WAYS*mem_pkg::TAG_W-1:0]  tag_vec,
   input  logic [mem_pkg::NUM_WAYS*mem_pkg::DATA_W-1:0] data_vec,
   output logic                                      any_hit,
   output logic [mem_pkg::DATA_W-1:0]                hit_data,
   output logic [mem_pkg::WAY_W-1:0]                 victim,
   output logic                                      wb_needed,
   output logic [mem_pkg::TAG_W-1:0]                 victim_tag,
   output logic [mem_pkg::DATA_W-1:0]                victim_data
);
   import mem_pkg::*;

   logic [WAY_W-1:0] candidate;
   // Fallback pointer when every way is valid
   logic [WAY_W-1:0] alt_ptr;

   assign any_hit = |hit;

   // At most one way hits per set
   always_comb begin
      hit_data = '0;
      for (int i = 0; i < NUM_WAYS; i++) begin
         if (hit[i]) begin
            hit_data = data_vec[i*DATA_W +: DATA_W];
         end
      end
   end

   // Lowest invalid way wins, else alternate
   always_comb begin
      candidate = alt_ptr;
      for (int i = NUM_WAYS - 1; i >= 0; i--) begin
         if (!valid[i]) begin
            candidate = WAY_W'(i);
         end
      end
   end

   // Candidate must be written back first
   assign wb_needed = valid[candidate] && dirty[candidate];

   always_ff @(posedge clk) begin
      if (rst) begin
         victim <= '0;
         alt_ptr <= '0;
      end else if (choose) begin
         victim <= candidate;
         alt_ptr <= alt_ptr + 1'b1;
      end
   end

   // Registered victim feeds write-back
   assign victim_tag = tag_vec[victim*TAG_W +: TAG_W];
   assign victim_data = data_vec[victim*DATA_W +: DATA_W];

endmodule

// File: block_memory.sv
`timescale 1ns/1ns

module block_memory (
   input  logic                            clk,
   input  logic [mem_pkg::MEM_ADDR_W-1:0]  mem_addr,
   input  logic [mem_pkg::DATA_W-1:0]      mem_wdata,
   input  logic                            mem_wr,
   input  logic                            mem_rd,
   output logic [mem_pkg::DATA_W-1:0]      mem_rdata,
   output logic                            mem_rvalid
);
   import mem_pkg::*;

   // Word array, all zero at start of simulation
   logic [DATA_W-1:0]           mem [MEM_WORDS] = '{default: '0};
   // Read pipeline, one stage per latency cycle
   logic [DATA_W-1:0]           rdata_pipe [MEM_READ_LATENCY];
   logic [MEM_READ_LATENCY-1:0] rvalid_pipe = '0;

   // Single-cycle write
   always_ff @(posedge clk) begin
      if (mem_wr) begin
         mem[mem_addr] <= mem_wdata;
      end
   end

   always_ff @(posedge clk) begin
      // First stage samples the array
      if (mem_rd) begin
         rdata_pipe[0] <= mem[mem_addr];
      end
      rvalid_pipe[0] <= mem_rd;
      // Remaining stages just shift, so reads overlap
      for (int i = 1; i < MEM_READ_LATENCY; i++) begin
         rdata_pipe[i] <= rdata_pipe[i-1];
         rvalid_pipe[i] <= rvalid_pipe[i-1];
      end
   end

   assign mem_rdata = rdata_pipe[MEM_READ_LATENCY-1];
   assign mem_rvalid = rvalid_pipe[MEM_READ_LATENCY-1];

endmodule

// File: cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [mem_pkg::ADDR_W-1:0]      addr,
   input  logic [mem_pkg::DATA_W-1:0]      data_in,
   input  logic                            rd,
   input  logic                            wr,
   input  logic                            any_hit,
   input  logic [mem_pkg::DATA_W-1:0]      hit_data,
   input  logic [mem_pkg::WAY_W-1:0]       victim,
   input  logic                            wb_needed,
   input  logic [mem_pkg::TAG_W-1:0]       victim_tag,
   input  logic [mem_pkg::DATA_W-1:0]      victim_data,
   input  logic [mem_pkg::DATA_W-1:0]      mem_rdata,
   input  logic                            mem_rvalid,
   output logic [mem_pkg::DATA_W-1:0]      data_out,
   output logic                            done,
   output logic                            stall,
   output logic                            cache_hit,
   output logic                            choose,
   output logic [mem_pkg::NUM_WAYS-1:0]    way_en,
   output logic [mem_pkg::INDEX_W-1:0]     index,
   output logic [mem_pkg::WORD_W-1:0]      word,
   output logic [mem_pkg::TAG_W-1:0]       tag,
   output logic [mem_pkg::DATA_W-1:0]      way_data_in,
   output logic                            way_wr,
   output logic                            fill,
   output logic                            mark_dirty,
   output logic [mem_pkg::MEM_ADDR_W-1:0]  mem_addr,
   output logic [mem_pkg::DATA_W-1:0]      mem_wdata,
   output logic                            mem_wr,
   output logic                            mem_rd
);
   import mem_pkg::*;

   logic [STATE_W-1:0] state;
   logic [STATE_W-1:0] state_n;
   // Issue count has an extra bit to mark all four reads sent
   logic [WORD_W:0]    issue_cnt;
   logic [WORD_W:0]    issue_cnt_n;
   // Words installed so far during fill
   logic [WORD_W-1:0]  fill_cnt;
   logic [WORD_W-1:0]  fill_cnt_n;
   logic               req;
   logic [TAG_W-1:0]   req_tag;
   logic [WORD_W-1:0]  req_word;

   // User holds the request until done, so no copy is kept
   assign req = rd || wr;
   assign req_tag = addr[TAG_LSB +: TAG_W];
   assign req_word = addr[WORD_LSB +: WORD_W];
   assign index = addr[INDEX_LSB +: INDEX_W];

   assign data_out = hit_data;
   assign stall = req && !done;

   always_comb begin
      state_n = state;
      issue_cnt_n = issue_cnt;
      fill_cnt_n = fill_cnt;
      done = 1'b0;
      cache_hit = 1'b0;
      choose = 1'b0;
      way_en = '0;
      word = req_word;
      tag = req_tag;
      way_data_in = data_in;
      way_wr = 1'b0;
      fill = 1'b0;
      mark_dirty = 1'b0;
      mem_addr = {index, req_tag, issue_cnt[WORD_W-1:0]};
      mem_wdata = victim_data;
      mem_wr = 1'b0;
      mem_rd = 1'b0;
      case (state)
         S_IDLE: begin
            if (req) begin
               // Compare mode on every way
               way_en = '1;
               way_wr = wr;
               mark_dirty = wr;
               if (any_hit) begin
                  done = 1'b1;
                  cache_hit = 1'b1;
               end else begin
                  choose = 1'b1;
                  issue_cnt_n = '0;
                  fill_cnt_n = '0;
                  state_n = wb_needed ? S_WRITEBACK : S_FILL;
               end
            end
         end
         S_WRITEBACK: begin
            // Old block goes back under the victim's tag
            way_en[victim] = 1'b1;
            word = issue_cnt[WORD_W-1:0];
            tag = victim_tag;
            mem_addr = {index, victim_tag, issue_cnt[WORD_W-1:0]};
            mem_wr = 1'b1;
            issue_cnt_n = issue_cnt + 1'b1;
            if (&issue_cnt[WORD_W-1:0]) begin
               issue_cnt_n = '0;
               state_n = S_FILL;
            end
         end
         S_FILL: begin
            way_en[victim] = 1'b1;
            word = fill_cnt;
            way_data_in = mem_rdata;
            // Reads go out back to back
            if (!issue_cnt[WORD_W]) begin
               mem_rd = 1'b1;
               issue_cnt_n = issue_cnt + 1'b1;
            end
            // Install each word as it returns
            if (mem_rvalid) begin
               way_wr = 1'b1;
               fill = 1'b1;
               fill_cnt_n = fill_cnt + 1'b1;
               if (&fill_cnt) begin
                  state_n = S_RETRY;
               end
            end
         end
         S_RETRY: begin
            // Block is resident now, finish the original access
            way_en = '1;
            way_wr = wr;
            mark_dirty = wr;
            done = 1'b1;
            state_n = S_IDLE;
         end
         default: begin
            state_n = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         issue_cnt <= '0;
         fill_cnt <= '0;
      end else begin
         state <= state_n;
         issue_cnt <= issue_cnt_n;
         fill_cnt <= fill_cnt_n;
      end
   end

endmodule

// File: mem_system.sv
`timescale 1ns/1ns

module mem_system (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [mem_pkg::ADDR_W-1:0]  addr,
   input  logic [mem_pkg::DATA_W-1:0]  data_in,
   input  logic                        rd,
   input  logic                        wr,
   output logic [mem_pkg::DATA_W-1:0]  data_out,
   output logic                        done,
   output logic                        stall,
   output logic                        cache_hit
);
   import mem_pkg::*;

   // Controller to ways
   logic [NUM_WAYS-1:0]        way_en;
   logic [INDEX_W-1:0]         index;
   logic [WORD_W-1:0]          word;
   logic [TAG_W-1:0]           tag;
   logic [DATA_W-1:0]          way_data_in;
   logic                       way_wr;
   logic                       fill;
   logic                       mark_dirty;
   // Per-way answers, concatenated
   logic [NUM_WAYS-1:0]        way_hit;
   logic [NUM_WAYS-1:0]        way_valid;
   logic [NUM_WAYS-1:0]        way_dirty;
   logic [NUM_WAYS*TAG_W-1:0]  way_tag;
   logic [NUM_WAYS*DATA_W-1:0] way_data;
   // Selector results
   logic                       any_hit;
   logic [DATA_W-1:0]          hit_data;
   logic [WAY_W-1:0]           victim;
   logic                       wb_needed;
   logic [TAG_W-1:0]           victim_tag;
   logic [DATA_W-1:0]          victim_data;
   logic                       choose;
   // Memory side
   logic [MEM_ADDR_W-1:0]      mem_addr;
   logic [DATA_W-1:0]          mem_wdata;
   logic                       mem_wr;
   logic                       mem_rd;
   logic [DATA_W-1:0]          mem_rdata;
   logic                       mem_rvalid;

   cache_ctrl u_ctrl (
      .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .any_hit(any_hit), .hit_data(hit_data), .victim(victim), .wb_needed(wb_needed),
      .victim_tag(victim_tag), .victim_data(victim_data),
      .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit),
      .choose(choose), .way_en(way_en), .index(index), .word(word), .tag(tag),
      .way_data_in(way_data_in), .way_wr(way_wr), .fill(fill), .mark_dirty(mark_dirty),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wr(mem_wr), .mem_rd(mem_rd)
   );

   // Identical ways share every input except the enable
   for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
      cache_way u_way (
         .clk(clk), .rst(rst), .en(way_en[g]), .index(index), .word(word),
         .tag_in(tag), .data_in(way_data_in), .wr(way_wr), .fill(fill),
         .mark_dirty(mark_dirty), .hit(way_hit[g]), .valid(way_valid[g]),
         .dirty(way_dirty[g]), .tag_out(way_tag[g*TAG_W +: TAG_W]),
         .data_out(way_data[g*DATA_W +: DATA_W])
      );
   end

   way_select u_sel (
      .clk(clk), .rst(rst), .choose(choose), .hit(way_hit), .valid(way_valid),
      .dirty(way_dirty), .tag_vec(way_tag), .data_vec(way_data),
      .any_hit(any_hit), .hit_data(hit_data), .victim(victim), .wb_needed(wb_needed),
      .victim_tag(victim_tag), .victim_data(victim_data)
   );

   block_memory u_mem (
      .clk(clk), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wr(mem_wr),
      .mem_rd(mem_rd), .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid)
   );

endmodule

// File: mem_system_assert.sv
`timescale 1ns/1ns

module mem_system_assert (
   input logic clk,
   input logic rst,
   input logic rd,
   input logic wr,
   input logic done,
   input logic stall,
   input logic cache_hit
);

   // Completion and back-pressure never overlap
   done_stall_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(done && stall))
      else $error("done and stall high in the same cycle");

   // Completion only answers a pending request
   done_needs_request: assert property (@(posedge clk) disable iff (rst)
      done |-> (rd || wr))
      else $error("done high without rd or wr");

   // Hit flag only qualifies a completion
   hit_needs_done: assert property (@(posedge clk) disable iff (rst)
      cache_hit |-> done)
      else $error("cache_hit high without done");

endmodule

bind mem_system mem_system_assert u_assert (
   .clk(clk),
   .rst(rst),
   .rd(rd),
   .wr(wr),
   .done(done),
   .stall(stall),
   .cache_hit(cache_hit)
);

// File: tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
   output logic clk,
   output logic rst
);

   // 40 ns period, first rising edge at 20 ns
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Reset seen by the DUT on the first two rising edges
   initial begin
      rst = 1'b1;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

// File: tb_mem_system.sv
`timescale 1ns/1ns

module tb_mem_system;
   import mem_pkg::*;

   // 250 accesses at up to 11 cycles plus the idle gaps, with margin
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int CLEAN_MISS_CYCLES = 7;
   localparam int DIRTY_MISS_CYCLES = 11;
   localparam int RANDOM_OPS = 200;

   logic              clk;
   logic              rst;
   logic [ADDR_W-1:0] addr = '0;
   logic [DATA_W-1:0] data_in = '0;
   logic              rd = 1'b0;
   logic              wr = 1'b0;
   logic [DATA_W-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;

   // Expected contents of the word memory
   logic [DATA_W-1:0] ref_mem [MEM_WORDS] = '{default: '0};
   int                error_count = 0;
   int                check_count = 0;
   int                tests_passed = 0;
   int                tests_failed = 0;
   int                cycle_count = 0;
   // Observed result of the latest access
   int                last_latency;
   logic              last_hit;
   logic [DATA_W-1:0] last_data;

   tb_clkgen u_clkgen (
      .clk(clk),
      .rst(rst)
   );

   mem_system dut (
      .clk(clk), .rst(rst), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit)
   );

   // Byte address from its fields, bit 0 left clear
   function automatic logic [ADDR_W-1:0] block_addr(input logic [INDEX_W-1:0] idx,
                                                    input logic [TAG_W-1:0] tg,
                                                    input logic [WORD_W-1:0] wd);
      return {idx, tg, wd, 1'b0};
   endfunction

   // Expected read data, one word per byte pair
   function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
      return ref_mem[a[ADDR_W-1:1]];
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   // One request held until done, stall checked while waiting
   task automatic run_access(input logic is_write, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d);
      int waited;
      waited = 0;
      @(posedge clk);
      addr <= a;
      data_in <= d;
      rd <= !is_write;
      wr <= is_write;
      @(negedge clk);
      while (!done) begin
         check_value("stall", 32'(stall), 32'd1);
         waited++;
         @(negedge clk);
      end
      check_value("stall", 32'(stall), 32'd0);
      last_latency = waited;
      last_hit = cache_hit;
      last_data = data_out;
      if (is_write) begin
         ref_mem[a[ADDR_W-1:1]] = d;
      end
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         tests_passed++;
         $display("PASS: %s", name);
      end else begin
         tests_failed++;
         $display("FAIL: %s, %0d errors", name, error_count - errors_before);
      end
   endtask

   // Every completed read against the reference model
   always @(negedge clk) begin
      if (!rst && done && rd) begin
         check_value("data_out", 32'(data_out), 32'(expected_word(addr)));
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests still running after %0d cycles", cycle_count);
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      int                errors_before;
      int                pick;
      logic [ADDR_W-1:0] a;
      logic [DATA_W-1:0] d;
      logic [ADDR_W-1:0] pool [16];

      void'($urandom(32'h9d3a33d4));
      // 16 addresses over 2 indices and 3 tags
      for (int k = 0; k < 16; k++) begin
         pool[k] = block_addr(INDEX_W'(8'h40 + k % 2), TAG_W'(5 + 3 * (k % 3)),
                              WORD_W'(k / 6));
      end

      // Reset values and stall during cold misses
      errors_before = error_count;
      while (rst) begin
         @(posedge clk);
      end
      @(negedge clk);
      check_value("done", 32'(done), 32'd0);
      check_value("stall", 32'(stall), 32'd0);
      check_value("cache_hit", 32'(cache_hit), 32'd0);
      run_access(1'b0, block_addr(8'h01, 5'h00, 2'd0), '0);
      run_access(1'b0, block_addr(8'h02, 5'h00, 2'd0), '0);
      @(negedge clk);
      check_value("stall", 32'(stall), 32'd0);
      report_test("reset state and stall", errors_before);

      // Cold read then immediate hit
      errors_before = error_count;
      a = block_addr(8'h10, 5'h03, 2'd1);
      run_access(1'b0, a, '0);
      check_value("latency", 32'(last_latency), 32'(CLEAN_MISS_CYCLES));
      check_value("cache_hit", 32'(last_hit), 32'd0);
      check_value("data_out", 32'(last_data), 32'd0);
      run_access(1'b0, a, '0);
      check_value("latency", 32'(last_latency), 32'd0);
      check_value("cache_hit", 32'(last_hit), 32'd1);
      report_test("read miss then hit", errors_before);

      // Write miss, read back, write hit in the same block
      errors_before = error_count;
      a = block_addr(8'h20, 5'h07, 2'd2);
      run_access(1'b1, a, 16'hc3a5);
      check_value("latency", 32'(last_latency), 32'(CLEAN_MISS_CYCLES));
      run_access(1'b0, a, '0);
      check_value("cache_hit", 32'(last_hit), 32'd1);
      a = block_addr(8'h20, 5'h07, 2'd3);
      run_access(1'b1, a, 16'h1e0f);
      check_value("latency", 32'(last_latency), 32'd0);
      check_value("cache_hit", 32'(last_hit), 32'd1);
      run_access(1'b0, a, '0);
      report_test("write then read", errors_before);

      // Four misses so far, pointer back at way 0
      // Third tag evicts the dirty first block
      errors_before = error_count;
      run_access(1'b1, block_addr(8'h30, 5'h01, 2'd1), 16'ha001);
      check_value("latency", 32'(last_latency), 32'(CLEAN_MISS_CYCLES));
      run_access(1'b1, block_addr(8'h30, 5'h02, 2'd1), 16'hb002);
      check_value("latency", 32'(last_latency), 32'(CLEAN_MISS_CYCLES));
      run_access(1'b1, block_addr(8'h30, 5'h03, 2'd1), 16'hc003);
      check_value("latency", 32'(last_latency), 32'(DIRTY_MISS_CYCLES));
      // First block comes back from memory
      run_access(1'b0, block_addr(8'h30, 5'h01, 2'd1), '0);
      check_value("cache_hit", 32'(last_hit), 32'd0);
      check_value("data_out", 32'(last_data), 32'h0000a001);
      run_access(1'b0, block_addr(8'h30, 5'h03, 2'd1), '0);
      report_test("dirty eviction", errors_before);

      // Random mix, address bit 0 toggled as a don't care
      errors_before = error_count;
      for (int n = 0; n < RANDOM_OPS; n++) begin
         pick = int'($urandom_range(15));
         a = pool[pick] | ADDR_W'($urandom_range(1));
         d = DATA_W'($urandom);
         if ($urandom_range(1) == 1) begin
            run_access(1'b1, a, d);
         end else begin
            run_access(1'b0, a, '0);
         end
      end
      report_test("random reads and writes", errors_before);

      $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
               tests_passed, tests_failed, check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: files.f
mem_pkg.sv
cache_way.sv
way_select.sv
block_memory.sv
cache_ctrl.sv
mem_system.sv
mem_system_assert.sv
tb_clkgen.sv
tb_mem_system.sv

// File: Makefile
TOP = tb_mem_system

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o sim
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi
	@grep -q "All tests passed!" sim.log

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log
